/* tb.f */
hw/sad_pkg.sv
hw/sad_reg_pkg.sv
hw/sad_reg_file.sv
hw/sad_sample_pipe.sv
hw/sad_diff_stage.sv
hw/sad_accum_bank.sv
hw/sad_trigger_ctrl.sv
hw/sad_x2_top.sv
test/tb_sad_x2.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sad_x2
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_sad_x2.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sad_x2;

    localparam int ref_samples = 32;
    localparam int threshold = 300;
    localparam int flush_len = 80;
    localparam int cycle_limit = 20000;
    localparam logic [31:0] seed = 32'h78d0_1230;

    logic                  adc_sampleclk;
    logic                  reset;
    sad_pkg::sample_t      adc_datain;
    logic                  armed;
    sad_reg_pkg::reg_bus_t reg_bus;
    logic [7:0]            reg_datao;
    logic                  trigger;

    logic [31:0]            lfsr;
    logic [7:0]             ref_bytes [ref_samples];
    logic [ref_samples-1:0] ref_mask;
    logic [7:0]             stream [$];   // samples driven while armed
    int                     cycles = 0;
    int                     edges = 0;
    logic                   trigger_q = 1'b0;

    sad_x2_top #(.ref_samples(ref_samples)) i_dut (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_datain    (adc_datain),
        .armed         (armed),
        .reg_bus       (reg_bus),
        .reg_datao     (reg_datao),
        .trigger       (trigger)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #5 adc_sampleclk = ~adc_sampleclk;
    end

    always @(posedge adc_sampleclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // rising edges of trigger, sampled away from the active edge
    always @(negedge adc_sampleclk) begin
        if (trigger && !trigger_q)
            edges = edges + 1;
        trigger_q = trigger;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            b = {b[6:0], lfsr[0]};
        end
    endtask

    // SAD of the window whose newest sample is stream[last], oldest lines up with ref 0
    function automatic int window_sad(input int last);
        int sad = 0;
        int d;
        for (int i = 0; i < ref_samples; i++) begin
            d = int'(stream[last - ref_samples + 1 + i]) - int'(ref_bytes[i]);
            if (ref_mask[i])
                sad += (d < 0) ? -d : d;
        end
        return sad;
    endfunction

    function automatic int count_match_runs();
        int runs = 0;
        bit prev = 1'b0;
        bit hit;
        for (int n = ref_samples - 1; n < stream.size(); n++) begin
            hit = window_sad(n) <= threshold;
            if (hit && !prev)
                runs++;   // consecutive matching windows count once
            prev = hit;
        end
        return runs;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input int offset, input logic [7:0] data);
        reg_bus.address = addr;
        reg_bus.bytecnt = 7'(offset);
        reg_bus.datai   = data;
        reg_bus.write   = 1'b1;
        @(posedge adc_sampleclk);
        #1;
        reg_bus.write = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr, input int offset,
                               input logic [7:0] expected);
        reg_bus.address = addr;
        reg_bus.bytecnt = 7'(offset);
        reg_bus.read    = 1'b1;
        @(negedge adc_sampleclk);
        check_value(name, expected, reg_datao);
        @(posedge adc_sampleclk);
        #1;
        reg_bus.read = 1'b0;
    endtask

    task automatic expect_status(input logic triggered, input int count);
        read_expect("status.triggered", sad_reg_pkg::addr_status, 0, {7'b0, triggered});
        read_expect("status.num_triggers[7:0]", sad_reg_pkg::addr_status, 1, count[7:0]);
        read_expect("status.num_triggers[15:8]", sad_reg_pkg::addr_status, 2, count[15:8]);
    endtask

    task automatic drive_sample(input logic [7:0] s);
        adc_datain = s;
        if (armed)
            stream.push_back(s);
        @(posedge adc_sampleclk);
        #1;
    endtask

    task automatic drive_random(input int n);
        logic [7:0] r;
        repeat (n) begin
            next_byte(r);
            drive_sample(r);
        end
    endtask

    // enabled positions get the reference plus a little noise
    task automatic drive_copy();
        logic [7:0] r;
        for (int i = 0; i < ref_samples; i++) begin
            next_byte(r);
            drive_sample(ref_mask[i] ? ref_bytes[i] + (r & 8'h03) : r);
        end
    endtask

    task automatic write_mask(input logic [ref_samples-1:0] m);
        ref_mask = m;
        for (int k = 0; k < ref_samples / 8; k++)
            write_reg(sad_reg_pkg::addr_refen, k, m[8*k +: 8]);
    endtask

    task automatic run_stream(input int copies);
        stream.delete();
        edges = 0;
        armed = 1'b1;
        drive_random(48);
        for (int c = 0; c < copies; c++) begin
            drive_copy();
            drive_random(48);
        end
        repeat (flush_len) drive_sample(8'hff);   // reference stays below 0x80
    endtask

    task automatic disarm();
        armed = 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        #1;
    endtask

    initial begin
        logic [7:0] b;
        int runs;
        lfsr = seed;
        reset = 1'b1;
        armed = 1'b0;
        adc_datain = '0;
        reg_bus = '0;
        ref_mask = '1;
        repeat (5) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;

        check_value("trigger", 0, trigger);
        expect_status(1'b0, 0);
        for (int k = 0; k < 4; k++)
            read_expect("threshold", sad_reg_pkg::addr_threshold, k, 8'h00);
        for (int k = 0; k < ref_samples / 8; k++)
            read_expect("refen", sad_reg_pkg::addr_refen, k, 8'hff);

        for (int i = 0; i < ref_samples; i++) begin
            next_byte(b);
            ref_bytes[i] = b & 8'h7f;
            write_reg(sad_reg_pkg::addr_reference, i, ref_bytes[i]);
        end
        for (int i = 0; i < ref_samples; i++)
            read_expect("reference", sad_reg_pkg::addr_reference, i, ref_bytes[i]);
        write_reg(sad_reg_pkg::addr_threshold, 0, 8'(threshold));
        write_reg(sad_reg_pkg::addr_threshold, 1, 8'(threshold >> 8));
        write_reg(sad_reg_pkg::addr_threshold, 2, 8'ha5);   // not stored
        write_reg(sad_reg_pkg::addr_threshold, 3, 8'h5a);
        read_expect("threshold[7:0]", sad_reg_pkg::addr_threshold, 0, 8'(threshold));
        read_expect("threshold[15:8]", sad_reg_pkg::addr_threshold, 1, 8'(threshold >> 8));
        read_expect("threshold[23:16]", sad_reg_pkg::addr_threshold, 2, 8'h00);
        read_expect("threshold[31:24]", sad_reg_pkg::addr_threshold, 3, 8'h00);
        write_reg(sad_reg_pkg::addr_multiple_triggers, 0, 8'h01);
        read_expect("multiple_triggers", sad_reg_pkg::addr_multiple_triggers, 0, 8'h01);

        // single copy, full mask
        write_mask('1);
        run_stream(1);
        expect_status(1'b1, count_match_runs());
        disarm();

        // every other position enabled
        write_mask({(ref_samples / 2){2'b01}});
        run_stream(4);
        runs = count_match_runs();
        expect_status(runs > 0, runs);
        check_value("trigger rising edges", runs, edges);
        disarm();

        write_reg(sad_reg_pkg::addr_multiple_triggers, 0, 8'h00);
        run_stream(3);
        expect_status(1'b1, 1);
        check_value("trigger rising edges", 1, edges);

        write_reg(sad_reg_pkg::addr_status, 0, 8'h00);
        repeat (2) drive_sample(8'hff);
        expect_status(1'b0, 0);
        disarm();
        write_reg(sad_reg_pkg::addr_multiple_triggers, 0, 8'h01);
        run_stream(1);
        expect_status(1'b1, count_match_runs());
        disarm();
        armed = 1'b1;
        repeat (3) drive_sample(8'hff);   // rising armed clears the counts
        expect_status(1'b0, 0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/sad_x2_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_x2_top #(
    parameter int ref_samples = 32   // even, at most 64
) (
    input  logic                  adc_sampleclk,
    input  logic                  reset,
    input  sad_pkg::sample_t      adc_datain,
    input  logic                  armed,
    input  sad_reg_pkg::reg_bus_t reg_bus,
    output logic [7:0]            reg_datao,
    output logic                  trigger
);

    sad_pkg::sample_t [ref_samples-1:0]   refsamples;
    logic [ref_samples-1:0]               refen;
    sad_reg_pkg::sad_cfg_t                cfg;
    logic                                 clear_status;
    sad_reg_pkg::status_t                 status;
    sad_pkg::sample_pair_t                pair;
    sad_pkg::sample_pair_t                pair_neg;
    logic                                 run;
    logic                                 arm_rise;
    logic                                 tick_tock;
    logic [$clog2(ref_samples)-1:0]       phase_index;
    sad_pkg::score_t [ref_samples/2-1:0]  incr;
    logic [ref_samples-1:0]               match;

    sad_reg_file #(.ref_samples(ref_samples)) i_reg_file (
        .adc_sampleclk, .reset, .reg_bus, .status, .reg_datao,
        .refsamples, .refen, .cfg, .clear_status
    );

    sad_sample_pipe #(.ref_samples(ref_samples)) i_sample_pipe (
        .adc_sampleclk, .reset, .armed, .adc_datain,
        .pair, .pair_neg, .run, .arm_rise, .tick_tock, .phase_index
    );

    sad_diff_stage #(.ref_samples(ref_samples)) i_diff_stage (
        .adc_sampleclk, .pair, .pair_neg, .tick_tock, .phase_index,
        .refsamples, .refen, .incr
    );

    sad_accum_bank #(.ref_samples(ref_samples)) i_accum_bank (
        .adc_sampleclk, .run, .tick_tock, .phase_index, .incr, .cfg, .match
    );

    sad_trigger_ctrl i_trigger_ctrl (
        .adc_sampleclk, .reset,
        .match        (|match),
        .cfg, .clear_status, .arm_rise, .trigger, .status
    );

endmodule

`default_nettype wire

/* hw/sad_trigger_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_trigger_ctrl (
    input  logic                  adc_sampleclk,
    input  logic                  reset,
    input  logic                  match,          // any window phase matched
    input  sad_reg_pkg::sad_cfg_t cfg,
    input  logic                  clear_status,
    input  logic                  arm_rise,
    output logic                  trigger,
    output sad_reg_pkg::status_t  status
);

    logic trigger_r;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger   <= 1'b0;
            trigger_r <= 1'b0;
            status    <= '0;
        end else begin
            trigger   <= match && !(status.triggered && !cfg.multiple_triggers);
            trigger_r <= trigger;
            if (clear_status || arm_rise) begin
                status <= '0;
            end else if (trigger && !trigger_r) begin
                // a run of matching windows counts once
                status.triggered    <= 1'b1;
                status.num_triggers <= status.num_triggers + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sad_accum_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_accum_bank #(
    parameter int ref_samples = 32
) (
    input  logic                                 adc_sampleclk,
    input  logic                                 run,
    input  logic                                 tick_tock,
    input  logic [$clog2(ref_samples)-1:0]       phase_index,
    input  sad_pkg::score_t [ref_samples/2-1:0]  incr,
    input  sad_reg_pkg::sad_cfg_t                cfg,
    output logic [ref_samples-1:0]               match
);

    localparam int phase_w   = $clog2(ref_samples);
    localparam int score_msb = sad_pkg::score_w - 1;
    localparam logic [phase_w-2:0] last_pair = (phase_w - 1)'(ref_samples / 2 - 1);

    // seed position lines counter 0 up with the first pair of a window
    localparam logic [ref_samples-1:0] restart_seed = ref_samples'(1) << (ref_samples - 3);

    logic                   ready_start;
    logic [ref_samples-1:0] restart;    // one hot, marks the counter whose window just closed
    logic [ref_samples-1:0] ready;
    sad_pkg::score_t        score [ref_samples];

    assign ready_start = (phase_index[phase_w-1:1] == last_pair);

    always_ff @(posedge adc_sampleclk) begin
        if (run) begin
            restart <= {restart[ref_samples-2:0], restart[ref_samples-1]};
            ready   <= {ready[ref_samples-2:0], ready[0] | ready_start};
        end else begin
            restart <= restart_seed;
            ready   <= '0;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        for (int j = 0; j < ref_samples; j++) begin
            // even counters add on odd phases, odd counters on even phases
            if (restart[j])
                score[j] <= incr[j/2];
            else if ((tick_tock == (j % 2 == 0)) && !score[j][score_msb])
                score[j] <= score[j] + incr[j/2];   // frozen once saturated

            match[j] <= restart[j] && ready[j] && (score[j] <= cfg.threshold);
        end
    end

endmodule

`default_nettype wire

/* hw/sad_diff_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_diff_stage #(
    parameter int ref_samples = 32
) (
    input  logic                                    adc_sampleclk,
    input  sad_pkg::sample_pair_t                   pair,
    input  sad_pkg::sample_pair_t                   pair_neg,
    input  logic                                    tick_tock,
    input  logic [$clog2(ref_samples)-1:0]          phase_index,
    input  sad_pkg::sample_t [ref_samples-1:0]      refsamples,
    input  logic [ref_samples-1:0]                  refen,
    output sad_pkg::score_t [ref_samples/2-1:0]     incr
);

    localparam int num_pairs = ref_samples / 2;
    localparam int phase_w   = $clog2(ref_samples);

    logic [phase_w-2:0]    pair_sel;        // reference pair feeding the chain
    sad_pkg::sample_pair_t pair_r;          // input pair, delayed to meet the decisions
    sad_pkg::sample_pair_t ref_chain [num_pairs];
    sad_pkg::sample_pair_t ref_r     [num_pairs];
    logic [1:0]            en_chain  [num_pairs];   // bit 0 goes with a, bit 1 with b
    logic [1:0]            en_r      [num_pairs];
    logic [1:0]            above     [num_pairs];   // input above reference

    // |x - r| in sample width, using the stored negative when x is below r
    function automatic sad_pkg::sample_t abs_term(
        input logic             en,
        input logic             gt,
        input sad_pkg::sample_t x,
        input sad_pkg::sample_t x_neg,
        input sad_pkg::sample_t r
    );
        sad_pkg::sample_t d;
        if (gt)
            d = x - r;
        else
            d = x_neg + r;
        return en ? d : '0;
    endfunction

    assign pair_sel = phase_index[phase_w-1:1];

    always_ff @(posedge adc_sampleclk) begin
        pair_r <= pair;

        ref_chain[0].a <= refsamples[{pair_sel, 1'b0}];
        ref_chain[0].b <= refsamples[{pair_sel, 1'b1}];
        en_chain[0]    <= {refen[{pair_sel, 1'b1}], refen[{pair_sel, 1'b0}]};

        // chain moves one slot every other cycle
        for (int p = 1; p < num_pairs; p++) begin
            if (!tick_tock) begin
                ref_chain[p] <= ref_chain[p-1];
                en_chain[p]  <= en_chain[p-1];
            end
        end

        for (int p = 0; p < num_pairs; p++) begin
            ref_r[p]    <= ref_chain[p];
            en_r[p]     <= en_chain[p];
            above[p][0] <= pair.a > ref_chain[p].a;
            above[p][1] <= pair.b > ref_chain[p].b;
            incr[p] <= sad_pkg::score_t'(abs_term(en_r[p][0], above[p][0],
                                                  pair_r.a, pair_neg.a, ref_r[p].a))
                     + sad_pkg::score_t'(abs_term(en_r[p][1], above[p][1],
                                                  pair_r.b, pair_neg.b, ref_r[p].b));
        end
    end

endmodule

`default_nettype wire

/* hw/sad_sample_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_sample_pipe #(
    parameter int ref_samples = 32
) (
    input  logic                             adc_sampleclk,
    input  logic                             reset,
    input  logic                             armed,
    input  sad_pkg::sample_t                 adc_datain,
    output sad_pkg::sample_pair_t            pair,
    output sad_pkg::sample_pair_t            pair_neg,
    output logic                             run,
    output logic                             arm_rise,
    output logic                             tick_tock,
    output logic [$clog2(ref_samples)-1:0]   phase_index
);

    localparam int phase_w = $clog2(ref_samples);
    localparam logic [phase_w-1:0] last_phase = phase_w'(ref_samples - 1);

    // two newest samples, overlapping by one from cycle to cycle
    always_ff @(posedge adc_sampleclk) begin
        pair.b     <= adc_datain;
        pair.a     <= pair.b;
        pair_neg.a <= -pair.a;   // lines up with the delayed pair in the diff stage
        pair_neg.b <= -pair.b;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            run      <= 1'b0;
            arm_rise <= 1'b0;
        end else begin
            run      <= armed;
            arm_rise <= armed && !run;   // high in the first cycle of run
        end
    end

    // window phase, held at zero while not running
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run)
            phase_index <= '0;
        else if (phase_index == last_phase)
            phase_index <= '0;
        else
            phase_index <= phase_index + 1'b1;
    end

    assign tick_tock = phase_index[0];

endmodule

`default_nettype wire

/* hw/sad_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_reg_file #(
    parameter int ref_samples = 32
) (
    input  logic                                     adc_sampleclk,
    input  logic                                     reset,
    input  sad_reg_pkg::reg_bus_t                    reg_bus,
    input  sad_reg_pkg::status_t                     status,
    output logic [7:0]                               reg_datao,
    output sad_pkg::sample_t [ref_samples-1:0]       refsamples,
    output logic [ref_samples-1:0]                   refen,
    output sad_reg_pkg::sad_cfg_t                    cfg,
    output logic                                     clear_status
);

    localparam int ref_idx_w   = $clog2(ref_samples);
    localparam int refen_idx_w = $clog2(ref_samples / 8);

    logic [ref_idx_w-1:0]   ref_idx;     // byte count wraps past the last sample
    logic [refen_idx_w-1:0] refen_idx;
    logic [1:0]             word_idx;    // byte of a 32-bit readback word
    logic [31:0]            threshold_wide;
    logic [31:0]            status_wide;

    assign ref_idx        = reg_bus.bytecnt[ref_idx_w-1:0];
    assign refen_idx      = reg_bus.bytecnt[refen_idx_w-1:0];
    assign word_idx       = reg_bus.bytecnt[1:0];
    assign threshold_wide = {16'b0, cfg.threshold};
    assign status_wide    = {8'b0, status};

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            refsamples   <= '0;
            refen        <= '1;   // every position compared by default
            cfg          <= '0;
            clear_status <= 1'b0;
        end else begin
            clear_status <= reg_bus.write && (reg_bus.address == sad_reg_pkg::addr_status);
            if (reg_bus.write) begin
                case (reg_bus.address)
                    sad_reg_pkg::addr_reference: refsamples[ref_idx] <= reg_bus.datai;
                    sad_reg_pkg::addr_refen: refen[8*refen_idx +: 8] <= reg_bus.datai;
                    sad_reg_pkg::addr_threshold: begin
                        if (reg_bus.bytecnt < 7'd2)   // upper two bytes are not stored
                            cfg.threshold[8*reg_bus.bytecnt[0] +: 8] <= reg_bus.datai;
                    end
                    sad_reg_pkg::addr_multiple_triggers: cfg.multiple_triggers <= reg_bus.datai[0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        reg_datao = 8'h00;
        if (reg_bus.read) begin
            case (reg_bus.address)
                sad_reg_pkg::addr_reference: reg_datao = refsamples[ref_idx];
                sad_reg_pkg::addr_refen: reg_datao = refen[8*refen_idx +: 8];
                sad_reg_pkg::addr_threshold: reg_datao = threshold_wide[8*word_idx +: 8];
                sad_reg_pkg::addr_status: reg_datao = status_wide[8*word_idx +: 8];
                sad_reg_pkg::addr_multiple_triggers: reg_datao = {7'b0, cfg.multiple_triggers};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/sad_reg_pkg.sv */
`default_nettype none

package sad_reg_pkg;

    localparam logic [7:0] addr_status            = 8'h00;  // write clears
    localparam logic [7:0] addr_threshold         = 8'h04;
    localparam logic [7:0] addr_reference         = 8'h05;  // one byte per reference sample
    localparam logic [7:0] addr_refen             = 8'h06;  // one bit per reference sample
    localparam logic [7:0] addr_multiple_triggers = 8'h07;

    typedef struct packed {
        logic [7:0] address;
        logic [6:0] bytecnt;   // byte offset within the register
        logic [7:0] datai;
        logic       write;
        logic       read;
    } reg_bus_t;

    typedef struct packed {
        sad_pkg::score_t threshold;
        logic            multiple_triggers;
    } sad_cfg_t;

    typedef struct packed {
        logic [15:0] num_triggers;
        logic [6:0]  reserved;    // reads as zero
        logic        triggered;
    } status_t;

endpackage

`default_nettype wire

/* hw/sad_pkg.sv */
`default_nettype none

package sad_pkg;

    // ADC sample width
    localparam int sample_w = 8;

    // score counter width, the MSB doubles as the saturation flag
    localparam int score_w = 16;

    typedef logic [sample_w-1:0] sample_t;
    typedef logic [score_w-1:0]  score_t;

    // two consecutive samples handled in one clock
    typedef struct packed {
        sample_t a;   // older sample
        sample_t b;   // newer sample
    } sample_pair_t;

endpackage

`default_nettype wire
